//--- verilog/display_pkg.sv
package display_pkg;

    // 640x480 raster
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_TOTAL   = 800;
    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_TOTAL   = 525;

    // kitchen grid, spans x 112..527 and y 112..367
    localparam int GRID_X0   = 112;
    localparam int GRID_Y0   = 112;
    localparam int CELL_SIZE = 32;
    localparam int GRID_COLS = 13;
    localparam int GRID_ROWS = 8;

    localparam int SPRITE_SIZE = 16;  // player square edge

    localparam int ORDER_X0     = 50;
    localparam int ORDER_PITCH  = 37;
    localparam int ORDER_Y0     = 50;
    localparam int ORDER_HEIGHT = 8;

    typedef logic [11:0] pixel_t;  // 4 bits each of r, g, b

    typedef enum logic [2:0] {
        WELCOME = 3'd0,
        START   = 3'd1,
        PLAY    = 3'd2,
        PAUSE   = 3'd3,
        FINISH  = 3'd4
    } game_phase_t;

    localparam pixel_t FLOOR_COLOR   = 12'hCA8;  // tiles
    localparam pixel_t WELCOME_COLOR = 12'h25B;
    localparam pixel_t FINISH_COLOR  = 12'h3A3;
    localparam pixel_t ORDER_COLOR   = 12'hF80;

    // code 0 is an empty cell and never gets drawn
    function automatic pixel_t object_color(input logic [3:0] code);
        pixel_t c;
        case (code)
            4'd0:    c = 12'h000;
            4'd1:    c = 12'h963;  // counter
            4'd2:    c = 12'hDDD;  // plate
            4'd3:    c = 12'h555;  // stove
            4'd4:    c = 12'h4C4;  // lettuce
            4'd5:    c = 12'hE22;  // tomato
            4'd6:    c = 12'hA52;  // meat
            4'd7:    c = 12'h48F;  // sink
            default: c = 12'hF0F;
        endcase
        return c;
    endfunction

    function automatic pixel_t player_color(input logic [3:0] state);
        pixel_t c;
        case (state)
            4'd0:    c = 12'h00F;  // idle
            4'd1:    c = 12'hF00;  // carrying
            4'd2:    c = 12'h0F0;  // chopping
            4'd3:    c = 12'hFF0;  // washing
            default: c = 12'h0FF;
        endcase
        return c;
    endfunction

endpackage

//--- verilog/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic       clock,
    input  logic       arst_n,
    output logic [9:0] hcount,
    output logic [9:0] vcount,
    output logic       hsync,
    output logic       vsync,
    output logic       blank,
    output logic       frame_end
);

    localparam int HS_START = display_pkg::H_VISIBLE + display_pkg::H_FRONT;  // 656
    localparam int HS_END   = HS_START + display_pkg::H_SYNC;                 // 752
    localparam int VS_START = display_pkg::V_VISIBLE + display_pkg::V_FRONT;  // 490
    localparam int VS_END   = VS_START + display_pkg::V_SYNC;                 // 492

    logic line_end;
    logic last_line;

    assign line_end  = (hcount == 10'(display_pkg::H_TOTAL - 1));
    assign last_line = (vcount == 10'(display_pkg::V_TOTAL - 1));

    // line-major scan, one pixel per clock
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
            if (last_line) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 10'd1;
            end
        end else begin
            hcount <= hcount + 10'd1;
        end
    end

    // decoded straight off the counters so they line up with hcount/vcount
    assign hsync = !((hcount >= 10'(HS_START)) && (hcount < 10'(HS_END)));
    assign vsync = !((vcount >= 10'(VS_START)) && (vcount < 10'(VS_END)));

    assign blank = (hcount >= 10'(display_pkg::H_VISIBLE)) ||
                   (vcount >= 10'(display_pkg::V_VISIBLE));

    // single cycle at (799,524), used as the frame tick
    assign frame_end = line_end && last_line;

endmodule

//--- verilog/game_phase_fsm.sv
`timescale 1ns/1ps

module game_phase_fsm #(
    parameter int START_FRAMES = 180,
    parameter int ROUND_FRAMES = 3600
) (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     start_btn,
    input  logic                     pause_btn,
    input  logic                     frame_end,
    output display_pkg::game_phase_t game_phase
);

    localparam int MAX_FRAMES = (START_FRAMES > ROUND_FRAMES) ? START_FRAMES : ROUND_FRAMES;
    localparam int CNT_W      = $clog2(MAX_FRAMES + 1);

    display_pkg::game_phase_t phase_next;
    logic [CNT_W-1:0]         frame_cnt;
    logic [CNT_W-1:0]         cnt_next;
    logic                     last_frame;

    // this frame tick takes the count to zero
    assign last_frame = frame_end && (frame_cnt <= CNT_W'(1));

    always_comb begin
        phase_next = game_phase;
        cnt_next   = frame_cnt;
        case (game_phase)
            display_pkg::WELCOME: begin
                if (start_btn) begin
                    phase_next = display_pkg::START;
                    cnt_next   = CNT_W'(START_FRAMES);
                end
            end
            display_pkg::START: begin  // countdown before the round
                if (last_frame) begin
                    phase_next = display_pkg::PLAY;
                    cnt_next   = CNT_W'(ROUND_FRAMES);
                end else if (frame_end) begin
                    cnt_next = frame_cnt - CNT_W'(1);
                end
            end
            display_pkg::PLAY: begin
                if (pause_btn) begin
                    phase_next = display_pkg::PAUSE;  // button beats a frame tick
                end else if (last_frame) begin
                    phase_next = display_pkg::FINISH;
                    cnt_next   = '0;
                end else if (frame_end) begin
                    cnt_next = frame_cnt - CNT_W'(1);
                end
            end
            display_pkg::PAUSE: begin
                if (pause_btn) begin
                    phase_next = display_pkg::PLAY;  // count held meanwhile
                end
            end
            display_pkg::FINISH: begin
                if (start_btn) begin
                    phase_next = display_pkg::WELCOME;
                end
            end
            default: phase_next = display_pkg::WELCOME;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            game_phase <= display_pkg::WELCOME;
            frame_cnt  <= '0;
        end else begin
            game_phase <= phase_next;
            frame_cnt  <= cnt_next;
        end
    end

endmodule

//--- verilog/player_sprite.sv
`timescale 1ns/1ps

module player_sprite (
    input  logic [9:0]          hcount,
    input  logic [9:0]          vcount,
    input  logic [8:0]          x,
    input  logic [8:0]          y,
    input  logic [3:0]          state,
    input  logic                enable,
    output logic                hit,
    output display_pkg::pixel_t color
);

    logic [9:0] x_end;
    logic [9:0] y_end;
    logic       in_x;
    logic       in_y;

    // one past the right and bottom edges
    assign x_end = {1'b0, x} + 10'(display_pkg::SPRITE_SIZE);
    assign y_end = {1'b0, y} + 10'(display_pkg::SPRITE_SIZE);

    assign in_x = (hcount >= {1'b0, x}) && (hcount < x_end);
    assign in_y = (vcount >= {1'b0, y}) && (vcount < y_end);

    // players past num_players stay dark
    assign hit = enable && in_x && in_y;

    // solid square, no facing direction drawn
    assign color = display_pkg::player_color(state);

endmodule

//--- verilog/grid_sprites.sv
`timescale 1ns/1ps

module grid_sprites (
    input  logic [9:0]          hcount,
    input  logic [9:0]          vcount,
    input  logic [display_pkg::GRID_ROWS-1:0][display_pkg::GRID_COLS-1:0][3:0] object_grid,
    output logic                hit,
    output display_pkg::pixel_t color
);

    localparam int GRID_X1 = display_pkg::GRID_X0 +
                             display_pkg::GRID_COLS * display_pkg::CELL_SIZE;  // 528
    localparam int GRID_Y1 = display_pkg::GRID_Y0 +
                             display_pkg::GRID_ROWS * display_pkg::CELL_SIZE;  // 368

    logic       in_grid;
    logic [9:0] dx;
    logic [9:0] dy;
    logic [3:0] col;
    logic [2:0] row;
    logic [3:0] code;

    assign in_grid = (hcount >= 10'(display_pkg::GRID_X0)) && (hcount < 10'(GRID_X1)) &&
                     (vcount >= 10'(display_pkg::GRID_Y0)) && (vcount < 10'(GRID_Y1));

    // offset into the grid, only meaningful when in_grid
    assign dx = hcount - 10'(display_pkg::GRID_X0);
    assign dy = vcount - 10'(display_pkg::GRID_Y0);

    assign col = 4'(dx / 10'(display_pkg::CELL_SIZE));
    assign row = 3'(dy / 10'(display_pkg::CELL_SIZE));

    always_comb begin
        code = 4'd0;
        if (in_grid) begin
            code = object_grid[row][col];
        end
    end

    assign hit   = (code != 4'd0);  // empty cells fall through
    assign color = display_pkg::object_color(code);

endmodule

//--- verilog/order_bars.sv
`timescale 1ns/1ps

module order_bars (
    input  logic [9:0]          hcount,
    input  logic [9:0]          vcount,
    input  logic [3:0]          orders,
    input  logic [3:0][4:0]     order_times,
    output logic                hit,
    output display_pkg::pixel_t color
);

    localparam int NUM_SLOTS = 4;

    logic       in_rows;
    logic [3:0] slot_hit;
    logic [9:0] slot_x0;
    logic [9:0] dx;

    assign in_rows = (vcount >= 10'(display_pkg::ORDER_Y0)) &&
                     (vcount < 10'(display_pkg::ORDER_Y0 + display_pkg::ORDER_HEIGHT));

    // bar width is the remaining time, so a zero time draws nothing
    always_comb begin
        slot_hit = '0;
        slot_x0  = '0;
        dx       = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_x0 = 10'(display_pkg::ORDER_X0 + i * display_pkg::ORDER_PITCH);
            dx      = hcount - slot_x0;
            slot_hit[i] = orders[i] && in_rows && (hcount >= slot_x0) &&
                          (dx < {5'd0, order_times[i]});
        end
    end

    assign hit   = |slot_hit;
    assign color = display_pkg::ORDER_COLOR;

endmodule

//--- verilog/graphics.sv
`timescale 1ns/1ps

module graphics #(
    parameter int MAX_PLAYERS = 4
) (
    input  logic                     clock,
    input  logic                     arst_n,
    input  display_pkg::game_phase_t game_phase,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     blank,
    input  logic [MAX_PLAYERS-1:0]   player_hit,
    input  display_pkg::pixel_t      player_color [MAX_PLAYERS],
    input  logic                     grid_hit,
    input  display_pkg::pixel_t      grid_color,
    input  logic                     order_hit,
    input  display_pkg::pixel_t      order_color,
    output logic                     hsync_out,
    output logic                     vsync_out,
    output logic                     blank_out,
    output display_pkg::pixel_t      pixel_out
);

    logic                player_sel;
    display_pkg::pixel_t player_pix;
    display_pkg::pixel_t pixel_next;

    // scan from the top index down so player 0 ends up on top
    always_comb begin
        player_sel = 1'b0;
        player_pix = '0;
        for (int i = MAX_PLAYERS - 1; i >= 0; i--) begin
            if (player_hit[i]) begin
                player_sel = 1'b1;
                player_pix = player_color[i];
            end
        end
    end

    // fixed layer priority
    always_comb begin
        if (blank) begin
            pixel_next = '0;
        end else if (game_phase == display_pkg::WELCOME) begin
            pixel_next = display_pkg::WELCOME_COLOR;
        end else if (game_phase == display_pkg::FINISH) begin
            pixel_next = display_pkg::FINISH_COLOR;
        end else if (player_sel) begin
            pixel_next = player_pix;
        end else if (grid_hit) begin
            pixel_next = grid_color;
        end else if (order_hit) begin
            pixel_next = order_color;
        end else begin
            pixel_next = display_pkg::FLOOR_COLOR;  // bare floor
        end
    end

    // one stage, syncs ride along with the pixel
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            blank_out <= 1'b1;
            pixel_out <= '0;
        end else begin
            hsync_out <= hsync;
            vsync_out <= vsync;
            blank_out <= blank;
            pixel_out <= pixel_next;
        end
    end

endmodule

//--- verilog/kitchen_display_top.sv
`timescale 1ns/1ps

module kitchen_display_top #(
    parameter int MAX_PLAYERS  = 4,
    parameter int START_FRAMES = 180,
    parameter int ROUND_FRAMES = 3600
) (
    input  logic                               clock,
    input  logic                               arst_n,
    input  logic                               start_btn,
    input  logic                               pause_btn,
    input  logic [$clog2(MAX_PLAYERS)-1:0]     num_players,  // count minus one
    input  logic [MAX_PLAYERS-1:0][8:0]        player_x,
    input  logic [MAX_PLAYERS-1:0][8:0]        player_y,
    input  logic [MAX_PLAYERS-1:0][3:0]        player_state,
    input  logic [display_pkg::GRID_ROWS-1:0][display_pkg::GRID_COLS-1:0][3:0] object_grid,
    input  logic [3:0]                         orders,
    input  logic [3:0][4:0]                    order_times,
    output logic                               hsync_out,
    output logic                               vsync_out,
    output logic                               blank_out,
    output display_pkg::pixel_t                pixel_out,
    output display_pkg::game_phase_t           game_phase
);

    logic [9:0]          hcount;
    logic [9:0]          vcount;
    logic                hsync;
    logic                vsync;
    logic                blank;
    logic                frame_end;
    logic [MAX_PLAYERS-1:0] player_en;
    logic [MAX_PLAYERS-1:0] player_hit;
    display_pkg::pixel_t player_color [MAX_PLAYERS];
    logic                grid_hit;
    display_pkg::pixel_t grid_color;
    logic                order_hit;
    display_pkg::pixel_t order_color;

    vga_timing i_vga_timing (
        .clock     (clock),
        .arst_n    (arst_n),
        .hcount    (hcount),
        .vcount    (vcount),
        .hsync     (hsync),
        .vsync     (vsync),
        .blank     (blank),
        .frame_end (frame_end)
    );

    game_phase_fsm #(
        .START_FRAMES (START_FRAMES),
        .ROUND_FRAMES (ROUND_FRAMES)
    ) i_game_phase_fsm (
        .clock      (clock),
        .arst_n     (arst_n),
        .start_btn  (start_btn),
        .pause_btn  (pause_btn),
        .frame_end  (frame_end),
        .game_phase (game_phase)
    );

    for (genvar p = 0; p < MAX_PLAYERS; p++) begin : g_player
        assign player_en[p] = (p <= int'(num_players));

        player_sprite i_player_sprite (
            .hcount (hcount),
            .vcount (vcount),
            .x      (player_x[p]),
            .y      (player_y[p]),
            .state  (player_state[p]),
            .enable (player_en[p]),
            .hit    (player_hit[p]),
            .color  (player_color[p])
        );
    end

    grid_sprites i_grid_sprites (
        .hcount      (hcount),
        .vcount      (vcount),
        .object_grid (object_grid),
        .hit         (grid_hit),
        .color       (grid_color)
    );

    order_bars i_order_bars (
        .hcount      (hcount),
        .vcount      (vcount),
        .orders      (orders),
        .order_times (order_times),
        .hit         (order_hit),
        .color       (order_color)
    );

    graphics #(
        .MAX_PLAYERS (MAX_PLAYERS)
    ) i_graphics (
        .clock        (clock),
        .arst_n       (arst_n),
        .game_phase   (game_phase),
        .hsync        (hsync),
        .vsync        (vsync),
        .blank        (blank),
        .player_hit   (player_hit),
        .player_color (player_color),
        .grid_hit     (grid_hit),
        .grid_color   (grid_color),
        .order_hit    (order_hit),
        .order_color  (order_color),
        .hsync_out    (hsync_out),
        .vsync_out    (vsync_out),
        .blank_out    (blank_out),
        .pixel_out    (pixel_out)
    );

endmodule

//--- testbench/display_checker.sv
`timescale 1ns/1ps

module display_checker #(
    parameter int MAX_PLAYERS  = 4,
    parameter int START_FRAMES = 2,
    parameter int ROUND_FRAMES = 4
) (
    input  logic                               clock,
    input  logic                               arst_n,
    input  logic                               start_btn,
    input  logic                               pause_btn,
    input  logic [$clog2(MAX_PLAYERS)-1:0]     num_players,
    input  logic [MAX_PLAYERS-1:0][8:0]        player_x,
    input  logic [MAX_PLAYERS-1:0][8:0]        player_y,
    input  logic [MAX_PLAYERS-1:0][3:0]        player_state,
    input  logic [display_pkg::GRID_ROWS-1:0][display_pkg::GRID_COLS-1:0][3:0] object_grid,
    input  logic [3:0]                         orders,
    input  logic [3:0][4:0]                    order_times,
    input  logic                               hsync_out,
    input  logic                               vsync_out,
    input  logic                               blank_out,
    input  display_pkg::pixel_t                pixel_out,
    input  display_pkg::game_phase_t           game_phase,
    input  logic                               row_done,
    input  int                                 row_idx,
    input  display_pkg::game_phase_t           row_phase,
    output int                                 error_count,
    output int                                 test_count
);

    localparam int HS_START = display_pkg::H_VISIBLE + display_pkg::H_FRONT;
    localparam int HS_END   = HS_START + display_pkg::H_SYNC;
    localparam int VS_START = display_pkg::V_VISIBLE + display_pkg::V_FRONT;
    localparam int VS_END   = VS_START + display_pkg::V_SYNC;
    localparam int GRID_X1  = display_pkg::GRID_X0 + display_pkg::GRID_COLS * display_pkg::CELL_SIZE;
    localparam int GRID_Y1  = display_pkg::GRID_Y0 + display_pkg::GRID_ROWS * display_pkg::CELL_SIZE;
    localparam int ORDER_Y1 = display_pkg::ORDER_Y0 + display_pkg::ORDER_HEIGHT;

    int                       hc;
    int                       vc;
    int                       cnt;
    int                       exp_hc;
    int                       exp_vc;
    int                       row_num;
    int                       test_err;
    display_pkg::game_phase_t ph;
    display_pkg::game_phase_t seen_phase;
    display_pkg::game_phase_t want_phase;
    logic                     exp_h;
    logic                     exp_v;
    logic                     exp_b;
    logic                     checking;
    logic                     row_pending;
    logic                     fe;
    display_pkg::pixel_t      exp_pix;

    // layers from top to bottom for one raster position
    function automatic display_pkg::pixel_t ref_pixel(int h, int v, display_pkg::game_phase_t p);
        int r;
        int c;
        int x0;
        if (h >= display_pkg::H_VISIBLE || v >= display_pkg::V_VISIBLE) return '0;
        if (p == display_pkg::WELCOME) return display_pkg::WELCOME_COLOR;
        if (p == display_pkg::FINISH) return display_pkg::FINISH_COLOR;
        for (int i = 0; i < MAX_PLAYERS; i++) begin
            if (i <= int'(num_players) && h >= int'(player_x[i]) && v >= int'(player_y[i]) &&
                h < int'(player_x[i]) + display_pkg::SPRITE_SIZE &&
                v < int'(player_y[i]) + display_pkg::SPRITE_SIZE)
                return display_pkg::player_color(player_state[i]);
        end
        if (h >= display_pkg::GRID_X0 && v >= display_pkg::GRID_Y0 &&
            h < GRID_X1 && v < GRID_Y1) begin
            c = (h - display_pkg::GRID_X0) / display_pkg::CELL_SIZE;
            r = (v - display_pkg::GRID_Y0) / display_pkg::CELL_SIZE;
            if (object_grid[r][c] != 4'd0) return display_pkg::object_color(object_grid[r][c]);
        end
        if (v >= display_pkg::ORDER_Y0 && v < ORDER_Y1) begin
            for (int i = 0; i < 4; i++) begin
                x0 = display_pkg::ORDER_X0 + i * display_pkg::ORDER_PITCH;
                if (orders[i] && h >= x0 && h - x0 < int'(order_times[i]))
                    return display_pkg::ORDER_COLOR;
            end
        end
        return display_pkg::FLOOR_COLOR;
    endfunction

    assign fe = (hc == display_pkg::H_TOTAL - 1) && (vc == display_pkg::V_TOTAL - 1);

    // model raster and phase with the expected outputs one cycle behind
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            hc          <= 0;
            vc          <= 0;
            cnt         <= 0;
            ph          <= display_pkg::WELCOME;
            exp_hc      <= 0;
            exp_vc      <= 0;
            exp_h       <= 1'b1;  // outputs sit at their reset values
            exp_v       <= 1'b1;
            exp_b       <= 1'b1;
            exp_pix     <= '0;
            checking    <= 1'b1;
            row_pending <= 1'b0;
        end else begin
            exp_hc  <= hc;
            exp_vc  <= vc;
            exp_h   <= !(hc >= HS_START && hc < HS_END);
            exp_v   <= !(vc >= VS_START && vc < VS_END);
            exp_b   <= (hc >= display_pkg::H_VISIBLE) || (vc >= display_pkg::V_VISIBLE);
            exp_pix <= ref_pixel(hc, vc, ph);
            if (hc == display_pkg::H_TOTAL - 1) begin
                hc <= 0;
                vc <= (vc == display_pkg::V_TOTAL - 1) ? 0 : vc + 1;
            end else begin
                hc <= hc + 1;
            end
            case (ph)
                display_pkg::WELCOME: begin
                    if (start_btn) begin
                        ph  <= display_pkg::START;
                        cnt <= START_FRAMES;
                    end
                end
                display_pkg::START: begin
                    if (fe) begin
                        if (cnt <= 1) begin
                            ph  <= display_pkg::PLAY;
                            cnt <= ROUND_FRAMES;
                        end else begin
                            cnt <= cnt - 1;
                        end
                    end
                end
                display_pkg::PLAY: begin
                    if (pause_btn) begin
                        ph <= display_pkg::PAUSE;  // button first
                    end else if (fe) begin
                        if (cnt <= 1) begin
                            ph <= display_pkg::FINISH;
                        end
                        cnt <= cnt - 1;
                    end
                end
                display_pkg::PAUSE: begin
                    if (pause_btn) begin
                        ph <= display_pkg::PLAY;
                    end
                end
                display_pkg::FINISH: begin
                    if (start_btn) begin
                        ph <= display_pkg::WELCOME;
                    end
                end
                default: ph <= display_pkg::WELCOME;
            endcase
            row_pending <= row_done;
            seen_phase  <= game_phase;
            want_phase  <= row_phase;
            row_num     <= row_idx;
        end
    end

    task automatic mismatch(input string what);
        test_err++;
        error_count++;
        if (test_err <= 10)
            $display("[FAIL] %0t (%0d,%0d) %s", $time, exp_hc, exp_vc, what);
    endtask

    initial begin
        error_count = 0;
        test_count  = 0;
        test_err    = 0;
    end

    // compare on the falling edge between DUT updates
    always @(negedge clock) begin
        if (checking) begin
            if (hsync_out !== exp_h || vsync_out !== exp_v || blank_out !== exp_b)
                mismatch($sformatf("sync/blank got %b%b%b exp %b%b%b", hsync_out, vsync_out,
                                   blank_out, exp_h, exp_v, exp_b));
            if (pixel_out !== exp_pix)
                mismatch($sformatf("pixel got %h exp %h", pixel_out, exp_pix));
            if (game_phase !== ph)
                mismatch($sformatf("phase got %0d exp %0d", game_phase, ph));
            if (row_pending) begin
                if (seen_phase !== want_phase)
                    mismatch($sformatf("end of test phase got %0d exp %0d",
                                       seen_phase, want_phase));
                $display("test %0d %s, %0d mismatches", row_num,
                         (test_err == 0) ? "ok" : "wrong", test_err);
                test_count++;
                test_err = 0;
            end
        end
    end

endmodule

//--- testbench/tb_kitchen_display.sv
`timescale 1ns/1ps

module tb_kitchen_display;

    localparam int NUM_ROWS        = 9;
    localparam int CYCLES_PER_FRAME = 800 * 525;

    logic clock, arst_n, start_btn, pause_btn, row_done, table_ready;
    logic [1:0] num_players;
    logic [3:0][8:0] player_x, player_y;
    logic [3:0][3:0] player_state;
    logic [7:0][12:0][3:0] object_grid;
    logic [3:0] orders;
    logic [3:0][4:0] order_times;
    logic hsync_out, vsync_out, blank_out;
    display_pkg::pixel_t pixel_out;
    display_pkg::game_phase_t game_phase, row_phase;
    int row_idx, error_count, test_count, total_frames;

    // stimulus table columns
    int btn_t [NUM_ROWS];  // 0 none, 1 start, 2 pause
    int nump_t [NUM_ROWS];
    int layout_t [NUM_ROWS];
    int fill_t [NUM_ROWS];  // 0 empty, 1 random, 2 checkerboard
    logic [3:0] ord_t [NUM_ROWS];
    logic [19:0] time_t [NUM_ROWS];
    int frames_t [NUM_ROWS];
    display_pkg::game_phase_t phase_t [NUM_ROWS];

    kitchen_display_top #(.MAX_PLAYERS(4), .START_FRAMES(2), .ROUND_FRAMES(4)) i_kitchen_display_top (
        .clock(clock), .arst_n(arst_n), .start_btn(start_btn), .pause_btn(pause_btn),
        .num_players(num_players), .player_x(player_x), .player_y(player_y),
        .player_state(player_state), .object_grid(object_grid), .orders(orders),
        .order_times(order_times), .hsync_out(hsync_out), .vsync_out(vsync_out),
        .blank_out(blank_out), .pixel_out(pixel_out), .game_phase(game_phase)
    );

    display_checker #(.MAX_PLAYERS(4), .START_FRAMES(2), .ROUND_FRAMES(4)) i_display_checker (
        .clock(clock), .arst_n(arst_n), .start_btn(start_btn), .pause_btn(pause_btn),
        .num_players(num_players), .player_x(player_x), .player_y(player_y),
        .player_state(player_state), .object_grid(object_grid), .orders(orders),
        .order_times(order_times), .hsync_out(hsync_out), .vsync_out(vsync_out),
        .blank_out(blank_out), .pixel_out(pixel_out), .game_phase(game_phase),
        .row_done(row_done), .row_idx(row_idx), .row_phase(row_phase),
        .error_count(error_count), .test_count(test_count)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic add_row(input int n, input int btn, input int nump, input int layout,
                           input int fill, input logic [3:0] ord, input logic [19:0] tim,
                           input int frames, input display_pkg::game_phase_t ph);
        btn_t[n] = btn; nump_t[n] = nump; layout_t[n] = layout; fill_t[n] = fill;
        ord_t[n] = ord; time_t[n] = tim; frames_t[n] = frames; phase_t[n] = ph;
    endtask

    task automatic place_players(input int layout);
        if (layout == 0) begin  // 0 and 1 overlap, 2 sits on the grid, 3 on the bars
            player_x = {9'd60, 9'd120, 9'd108, 9'd100};
            player_y = {9'd45, 9'd120, 9'd104, 9'd100};
        end else begin
            player_x = {9'd60, 9'd400, 9'd310, 9'd300};
            player_y = {9'd45, 9'd200, 9'd310, 9'd300};
        end
        player_state = {4'd3, 4'd2, 4'd1, 4'd0};
    endtask

    task automatic fill_grid(input int fill);
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 13; c++) begin
                if (fill == 1) object_grid[r][c] = 4'($urandom % 9);
                else if (fill == 2) object_grid[r][c] = ((r + c) % 2 == 1) ? 4'((r * 13 + c) % 7 + 1) : 4'd0;
                else object_grid[r][c] = 4'd0;
            end
        end
    endtask

    // watchdog sized from the table
    initial begin
        wait (table_ready === 1'b1);
        #(total_frames * CYCLES_PER_FRAME * 8.0 + 20000.0);
        $display("timeout: the stimulus did not finish in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(32'ha06a97af));
        table_ready = 1'b0;
        add_row(0, 0, 3, 0, 0, 4'b0000, 20'd0, 1, display_pkg::WELCOME);
        add_row(1, 1, 3, 0, 2, 4'b1111, {5'd31, 5'd20, 5'd10, 5'd5}, 1, display_pkg::START);
        add_row(2, 0, 2, 0, 2, 4'b1011, {5'd12, 5'd25, 5'd0, 5'd31}, 1, display_pkg::PLAY);
        add_row(3, 0, 3, 1, 1, 4'b1111, {5'd7, 5'd19, 5'd28, 5'd1}, 1, display_pkg::PLAY);
        add_row(4, 2, 1, 1, 1, 4'b0110, {5'd3, 5'd30, 5'd14, 5'd9}, 2, display_pkg::PAUSE);
        add_row(5, 2, 0, 0, 2, 4'b1001, {5'd22, 5'd6, 5'd11, 5'd16}, 1, display_pkg::PLAY);
        add_row(6, 0, 3, 0, 0, 4'b0101, {5'd9, 5'd0, 5'd20, 5'd17}, 1, display_pkg::PLAY);
        add_row(7, 0, 3, 1, 1, 4'b1111, {5'd31, 5'd31, 5'd31, 5'd31}, 1, display_pkg::FINISH);
        add_row(8, 1, 3, 0, 2, 4'b1111, {5'd4, 5'd8, 5'd16, 5'd24}, 1, display_pkg::WELCOME);
        total_frames = 0;
        for (int n = 0; n < NUM_ROWS; n++) total_frames += frames_t[n];
        table_ready = 1'b1;

        arst_n = 1'b0; start_btn = 1'b0; pause_btn = 1'b0; row_done = 1'b0; row_idx = 0;
        row_phase = display_pkg::WELCOME; num_players = 2'd3; orders = '0; order_times = '0;
        place_players(0);
        fill_grid(0);
        repeat (3) @(negedge clock);
        arst_n = 1'b1;

        for (int n = 0; n < NUM_ROWS; n++) begin
            num_players = 2'(nump_t[n]);
            place_players(layout_t[n]);
            fill_grid(fill_t[n]);
            orders      = ord_t[n];
            order_times = time_t[n];
            start_btn   = (btn_t[n] == 1);
            pause_btn   = (btn_t[n] == 2);
            @(negedge clock);
            start_btn = 1'b0;
            pause_btn = 1'b0;
            row_done  = 1'b0;
            repeat (frames_t[n] * CYCLES_PER_FRAME - 1) @(negedge clock);
            row_done  = 1'b1;  // checker samples the phase at the next rising edge
            row_idx   = n;
            row_phase = phase_t[n];
        end
        @(negedge clock);
        row_done = 1'b0;
        @(negedge clock);

        $display("tests run %0d, mismatches %0d", test_count, error_count);
        if (error_count == 0 && test_count == NUM_ROWS) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- kitchen_display_top.f
verilog/display_pkg.sv
verilog/vga_timing.sv
verilog/game_phase_fsm.sv
verilog/player_sprite.sv
verilog/grid_sprites.sv
verilog/order_bars.sv
verilog/graphics.sv
verilog/kitchen_display_top.sv
testbench/display_checker.sv
testbench/tb_kitchen_display.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the kitchen display testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_kitchen_display \
    -f kitchen_display_top.f \
    --Mdir obj_dir -o sim_kitchen

./obj_dir/sim_kitchen | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation finished without failures"
exit 0
